//--- Makefile
# Verilator build and run of the data engine testbench
TOP := data_engine_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f data_engine.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/data_engine_tb.sv
// ----------------------------------------------------------
// data engine testbench with random stimulus and test sequence
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_params.svh"

module data_engine_tb;
   import dataeng_pkg::*;

   localparam int POLL_LIMIT = 400;

   logic                rst;
   logic                clk;
   logic                ctr_valid;
   logic                ctr_we;
   ctr_addr_t           ctr_addr;
   data_t               ctr_wdata;
   data_t               ctr_rdata;
   logic                data_valid;
   logic                data_we;
   logic [`DADDR_W-1:0] data_addr;
   data_t               data_wdata;
   data_t               data_rdata;
   logic [2:0]          test_id;
   int                  checks;
   int                  errors;
   int                  timeouts;
   int                  err_mark;
   data_t               rnd_state;
   data_t               cfg [`N_CONF];

   data_engine u_dut (
      .rst        (rst),
      .clk        (clk),
      .ctr_valid  (ctr_valid),
      .ctr_we     (ctr_we),
      .ctr_addr   (ctr_addr),
      .ctr_wdata  (ctr_wdata),
      .ctr_rdata  (ctr_rdata),
      .data_valid (data_valid),
      .data_we    (data_we),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_rdata (data_rdata)
   );

   engine_checker u_chk (
      .rst        (rst),
      .clk        (clk),
      .test_id    (test_id),
      .ctr_valid  (ctr_valid),
      .ctr_we     (ctr_we),
      .ctr_addr   (ctr_addr),
      .ctr_wdata  (ctr_wdata),
      .ctr_rdata  (ctr_rdata),
      .data_valid (data_valid),
      .data_we    (data_we),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_rdata (data_rdata),
      .checks     (checks),
      .errors     (errors)
   );

   // clock on rst with a 40 ns period
   always #20 rst = ~rst;

   function automatic data_t xorshift(data_t x);
      data_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic draw(output data_t v);
      rnd_state = xorshift(rnd_state);
      v = rnd_state;
   endtask

   task automatic ctr_access(logic we, int addr, data_t wdata);
      @(posedge rst);
      #2;
      ctr_valid = 1'b1;
      ctr_we    = we;
      ctr_addr  = addr[`CTR_ADDR_W-1:0];
      ctr_wdata = wdata;
   endtask

   task automatic data_access(logic we, int addr, data_t wdata);
      @(posedge rst);
      #2;
      data_valid = 1'b1;
      data_we    = we;
      data_addr  = addr[`DADDR_W-1:0];
      data_wdata = wdata;
   endtask

   task automatic release_bus();
      @(posedge rst);
      #2;
      ctr_valid  = 1'b0;
      data_valid = 1'b0;
   endtask

   // poll the status word until busy drops
   task automatic wait_idle();
      int   polls;
      logic busy;
      polls = 0;
      busy  = 1'b1;
      while (busy && polls < POLL_LIMIT) begin
         ctr_access(1'b0, `RUN_ADDR, '0);
         @(posedge rst);
         #2;
         ctr_valid = 1'b0;
         busy      = ctr_rdata[0];
         polls     = polls + 1;
      end
      if (busy) begin
         timeouts = timeouts + 1;
         $display("test %0d: engine still busy after %0d status polls", test_id, polls);
      end
   endtask

   function automatic data_t port_w0(int start, int incr, int count);
      return data_t'((count << 16) | (incr << 8) | start);
   endfunction

   function automatic data_t port_w1(logic wr, int src, int delay);
      return data_t'((delay << 8) | (src << 4) | (int'(wr) << 1) | 1);
   endfunction

   task automatic clear_cfg();
      for (int i = 0; i < `N_CONF; i++) begin
         cfg[i] = '0;
      end
   endtask

   task automatic load_cfg();
      for (int i = 0; i < `N_CONF; i++) begin
         ctr_access(1'b1, i, cfg[i]);
      end
   endtask

   task automatic run_engine();
      load_cfg();
      ctr_access(1'b1, `RUN_ADDR, 32'd1);
      wait_idle();
   endtask

   task automatic read_region(int mem, int start, int count);
      for (int k = 0; k < count; k++) begin
         data_access(1'b0, mem * 256 + (start + k) % 256, '0);
      end
   endtask

   task automatic begin_test(int id);
      test_id  = 3'(id);
      err_mark = errors + timeouts;
   endtask

   task automatic end_test();
      int n;
      release_bus();
      // let the last read return be compared
      @(posedge rst);
      #2;
      n = errors + timeouts - err_mark;
      if (n == 0) begin
         $display("test %0d finished: ok", test_id);
      end else begin
         $display("test %0d finished: %0d failures", test_id, n);
      end
   endtask

   initial begin
      data_t w;
      int    count;
      rst        = 1'b0;
      clk        = 1'b1;
      ctr_valid  = 1'b0;
      ctr_we     = 1'b0;
      ctr_addr   = '0;
      ctr_wdata  = '0;
      data_valid = 1'b0;
      data_we    = 1'b0;
      data_addr  = '0;
      data_wdata = '0;
      test_id    = 3'd0;
      timeouts   = 0;
      err_mark   = 0;
      rnd_state  = 32'd49193;
      repeat (8) @(posedge rst);
      #2;
      clk = 1'b0;

      begin_test(1);
      ctr_access(1'b0, `RUN_ADDR, '0);
      for (int i = 0; i < `N_CONF; i++) begin
         draw(w);
         ctr_access(1'b1, i, w);
      end
      for (int i = 0; i < `N_CONF; i++) begin
         ctr_access(1'b0, i, '0);
      end
      end_test();

      begin_test(2);
      for (int a = 0; a < 512; a++) begin
         draw(w);
         data_access(1'b1, a, w);
      end
      read_region(0, 0, 256);
      read_region(1, 0, 256);
      end_test();

      // random stride out of mem0 packed into mem1
      begin_test(3);
      draw(w);
      count = 1 + int'(w[4:0]);
      clear_cfg();
      cfg[0] = port_w0(int'(w[15:8]), int'(w[23:16]), count);
      cfg[1] = port_w1(1'b0, 0, 0);
      cfg[4] = port_w0(128, 1, count);
      cfg[5] = port_w1(1'b1, `BUS_MEM0A, 1);
      run_engine();
      read_region(1, 0, 256);
      end_test();

      begin_test(4);
      for (int op = 0; op < 8; op++) begin
         draw(w);
         clear_cfg();
         cfg[0] = port_w0(int'(w[7:0]), 1, 8);
         cfg[1] = port_w1(1'b0, 0, 0);
         cfg[2] = port_w0(int'(w[15:8]), 1, 8);
         cfg[3] = port_w1(1'b0, 0, 0);
         cfg[`CONF_ALU0] = data_t'(op | (`BUS_MEM0A << 4) | ((`BUS_MEM0A + 1) << 8));
         cfg[4] = port_w0(8 * op, 1, 8);
         cfg[5] = port_w1(1'b1, `BUS_ALU0, 2);
         run_engine();
         read_region(1, 8 * op, 8);
         // host stays off the data port during the next run
         release_bus();
      end
      end_test();

      // product into mem1B and ALU1 adding the constant one into mem1A
      begin_test(5);
      draw(w);
      clear_cfg();
      cfg[0] = port_w0(int'(w[7:0]), 3, 16);
      cfg[1] = port_w1(1'b0, 0, 0);
      cfg[2] = port_w0(int'(w[15:8]), 5, 16);
      cfg[3] = port_w1(1'b0, 0, 0);
      cfg[`CONF_ALU0 + 1] = data_t'((`BUS_ONE << 4) | (`BUS_MEM0A << 8));
      cfg[`CONF_MUL0] = data_t'(`BUS_MEM0A | ((`BUS_MEM0A + 1) << 4));
      cfg[4] = port_w0(64, 1, 16);
      cfg[5] = port_w1(1'b1, `BUS_ALU0 + 1, 2);
      cfg[6] = port_w0(192, 1, 16);
      cfg[7] = port_w1(1'b1, `BUS_MUL0, 3);
      run_engine();
      read_region(1, 64, 16);
      read_region(1, 192, 16);
      end_test();

      begin_test(6);
      draw(w);
      clear_cfg();
      cfg[0] = port_w0(int'(w[7:0]), 1, 64);
      cfg[1] = port_w1(1'b0, 0, 0);
      cfg[4] = port_w0(16, 1, 64);
      cfg[5] = port_w1(1'b1, `BUS_MEM0A, 1);
      load_cfg();
      ctr_access(1'b1, `RUN_ADDR, 32'd1);
      // move the copy target and try a second run mid-flight
      ctr_access(1'b1, 4, port_w0(144, 1, 64));
      ctr_access(1'b1, `RUN_ADDR, 32'd1);
      wait_idle();
      read_region(1, 0, 256);
      for (int i = 0; i < `N_CONF; i++) begin
         ctr_access(1'b0, i, '0);
      end
      end_test();

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && checks > 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- bench/engine_checker.sv
// ----------------------------------------------------------
// engine checker that models memories and config and checks reads
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_params.svh"

module engine_checker (
   input  logic                      rst,
   input  logic                      clk,
   input  logic [2:0]                test_id,
   input  logic                      ctr_valid,
   input  logic                      ctr_we,
   input  dataeng_pkg::ctr_addr_t    ctr_addr,
   input  dataeng_pkg::data_t        ctr_wdata,
   input  dataeng_pkg::data_t        ctr_rdata,
   input  logic                      data_valid,
   input  logic                      data_we,
   input  logic [`DADDR_W-1:0]       data_addr,
   input  dataeng_pkg::data_t        data_wdata,
   input  dataeng_pkg::data_t        data_rdata,
   output int                        checks,
   output int                        errors
);
   import dataeng_pkg::*;

   data_t mem_m  [2][2**`MEM_ADDR_W];
   data_t snap   [2][2**`MEM_ADDR_W];
   data_t conf_m [`N_CONF];
   data_t shadow [`N_CONF];
   int    cyc;
   int    run_edge;
   int    end_edge;
   logic  ctr_pend;
   logic  data_pend;
   int    ctr_pend_addr;
   int    data_pend_addr;
   data_t ctr_exp;
   data_t data_exp;

   function automatic string test_name(logic [2:0] id);
      case (id)
         3'd1: return "conf_readback";
         3'd2: return "mem_load";
         3'd3: return "strided_copy";
         3'd4: return "alu_ops";
         3'd5: return "mul_const";
         3'd6: return "run_while_busy";
         default: return "reset";
      endcase
   endfunction

   // busy as seen just before edge e
   function automatic logic busy_at(int e);
      return (e > run_edge) && (e <= end_edge);
   endfunction

   // value of a constant or memory read entry for element k of a run
   function automatic data_t leaf_val(int sel, int k);
      data_t     w0;
      int        p;
      mem_addr_t a;
      if (sel == `BUS_ONE) begin
         return data_t'(1);
      end
      if (sel < `BUS_MEM0A || sel > `BUS_MEM0A + 3) begin
         return '0;
      end
      p  = sel - `BUS_MEM0A;
      w0 = shadow[2*p];
      a  = mem_addr_t'(int'(w0[7:0]) + k * int'(w0[15:8]));
      return snap[p/2][a];
   endfunction

   // ALU and MUL entries take their operands from leaf entries
   function automatic data_t entry_val(int sel, int k);
      data_t w;
      data_t a;
      data_t b;
      if (sel == `BUS_MUL0) begin
         w = shadow[`CONF_MUL0];
         return leaf_val(int'(w[3:0]), k) * leaf_val(int'(w[7:4]), k);
      end
      if (sel < `BUS_ALU0 || sel > `BUS_ALU0 + 1) begin
         return leaf_val(sel, k);
      end
      w = shadow[`CONF_ALU0 + sel - `BUS_ALU0];
      a = leaf_val(int'(w[7:4]), k);
      b = leaf_val(int'(w[11:8]), k);
      case (w[2:0])
         3'd0: return a + b;
         3'd1: return a - b;
         3'd2: return a & b;
         3'd3: return a | b;
         3'd4: return a ^ b;
         3'd5: return (int'(a) > int'(b)) ? a : b;
         3'd6: return (int'(a) < int'(b)) ? a : b;
         default: return a;
      endcase
   endfunction

   task automatic run_model(int e);
      data_t     w0;
      data_t     w1;
      int        p;
      int        last;
      mem_addr_t a;
      last = 0;
      for (int i = 0; i < `N_CONF; i++) begin
         shadow[i] = conf_m[i];
      end
      for (int m = 0; m < 2; m++) begin
         for (int j = 0; j < 2**`MEM_ADDR_W; j++) begin
            snap[m][j] = mem_m[m][j];
         end
      end
      for (int m = 0; m < 2; m++) begin
         // port B first so port A wins an address clash
         for (int b = 1; b >= 0; b--) begin
            p  = 2*m + b;
            w0 = shadow[2*p];
            w1 = shadow[2*p+1];
            if (w1[0] && int'(w0[23:16]) != 0) begin
               if (int'(w1[11:8]) + int'(w0[23:16]) > last) begin
                  last = int'(w1[11:8]) + int'(w0[23:16]);
               end
               for (int k = 0; w1[1] && k < int'(w0[23:16]); k++) begin
                  a = mem_addr_t'(int'(w0[7:0]) + k * int'(w0[15:8]));
                  mem_m[m][a] = entry_val(int'(w1[7:4]), k);
               end
            end
         end
      end
      // busy clears one cycle after the last port is done
      run_edge = e;
      end_edge = e + last + 2;
   endtask

   task automatic check_word(string kind, int addr, data_t exp, data_t act);
      checks = checks + 1;
      if (act !== exp) begin
         errors = errors + 1;
         $display("MISMATCH %s %s addr %0d: expected %08h, actual %08h",
                  test_name(test_id), kind, addr, exp, act);
      end
   endtask

   always @(posedge rst or posedge clk) begin
      if (clk) begin
         cyc       = 0;
         run_edge  = 0;
         end_edge  = 0;
         ctr_pend  = 1'b0;
         data_pend = 1'b0;
         checks    = 0;
         errors    = 0;
         for (int i = 0; i < `N_CONF; i++) begin
            conf_m[i] = '0;
         end
      end else begin
         cyc = cyc + 1;
         if (ctr_pend) begin
            check_word("control read", ctr_pend_addr, ctr_exp, ctr_rdata);
         end
         if (data_pend) begin
            check_word("data read", data_pend_addr, data_exp, data_rdata);
         end
         ctr_pend       = ctr_valid && !ctr_we;
         data_pend      = data_valid && !data_we;
         ctr_pend_addr  = int'(ctr_addr);
         data_pend_addr = int'(data_addr);
         if (ctr_pend) begin
            ctr_exp = '0;
            if (int'(ctr_addr) < `N_CONF) begin
               ctr_exp = conf_m[ctr_addr];
            end else if (int'(ctr_addr) == `RUN_ADDR) begin
               ctr_exp = {31'd0, busy_at(cyc)};
            end
         end
         if (ctr_valid && ctr_we) begin
            if (int'(ctr_addr) < `N_CONF) begin
               conf_m[ctr_addr] = ctr_wdata;
            end else if (int'(ctr_addr) == `RUN_ADDR && ctr_wdata[0] && !busy_at(cyc)) begin
               run_model(cyc);
            end
         end
         if (data_pend) begin
            data_exp = mem_m[data_addr[8]][data_addr[7:0]];
         end
         if (data_valid && data_we) begin
            mem_m[data_addr[8]][data_addr[7:0]] = data_wdata;
         end
      end
   end

endmodule

//--- data_engine.f
+incdir+hw
hw/dataeng_pkg.sv
hw/mem_host_if.sv
hw/conf_regs.sv
hw/data_mem.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/data_engine.sv
bench/engine_checker.sv
bench/data_engine_tb.sv

//--- hw/alu_unit.sv
// ----------------------------------------------------------
// two-operand ALU fed from the data bus, one register stage
// ----------------------------------------------------------
`timescale 1ns/1ps

module alu_unit (
   input  logic                rst,
   input  logic                clk,
   input  dataeng_pkg::bus_t   data_bus,
   input  dataeng_pkg::data_t  conf,
   output dataeng_pkg::data_t  result
);
   import dataeng_pkg::*;

   alu_op_e op;
   data_t   op_a;
   data_t   op_b;
   data_t   alu_out;

   // opcode in 2:0, operand selects in 7:4 and 11:8
   assign op   = alu_op_e'(conf[2:0]);
   assign op_a = bus_pick(data_bus, bus_sel_t'(conf[7:4]));
   assign op_b = bus_pick(data_bus, bus_sel_t'(conf[11:8]));

   always_comb begin
      case (op)
         alu_add:    alu_out = op_a + op_b;
         alu_sub:    alu_out = op_a - op_b;
         alu_and:    alu_out = op_a & op_b;
         alu_or:     alu_out = op_a | op_b;
         alu_xor:    alu_out = op_a ^ op_b;
         // max and min compare as signed words
         alu_max:    alu_out = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
         alu_min:    alu_out = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
         alu_pass_a: alu_out = op_a;
         default:    alu_out = op_a;
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else begin
         result <= alu_out;
      end
   end

endmodule

//--- hw/conf_regs.sv
// ----------------------------------------------------------
// configuration registers with shadow copy, run and status
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_params.svh"

module conf_regs (
   input  logic                                 rst,
   input  logic                                 clk,
   input  logic                                 ctr_valid,
   input  logic                                 ctr_we,
   input  dataeng_pkg::ctr_addr_t               ctr_addr,
   input  dataeng_pkg::data_t                   ctr_wdata,
   output dataeng_pkg::data_t                   ctr_rdata,
   input  logic [2*`N_MEM-1:0]                  port_done,
   output dataeng_pkg::data_t [4*`N_MEM-1:0]    mem_conf,
   output dataeng_pkg::data_t [`N_ALU-1:0]      alu_conf,
   output dataeng_pkg::data_t                   mul_conf,
   output logic                                 run_pulse
);
   import dataeng_pkg::*;

   data_t conf_q   [`N_CONF];
   data_t shadow_q [`N_CONF];
   logic  busy_q;
   logic  wr_en;
   logic  run_req;

   assign wr_en   = ctr_valid && ctr_we;
   // a run request while busy is dropped
   assign run_req = wr_en && (ctr_addr == `RUN_ADDR) && ctr_wdata[0] && !busy_q;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         for (int i = 0; i < `N_CONF; i++) begin
            conf_q[i]   <= '0;
            shadow_q[i] <= '0;
         end
         run_pulse <= 1'b0;
         busy_q    <= 1'b0;
         ctr_rdata <= '0;
      end else begin
         if (wr_en && ctr_addr < `N_CONF) begin
            conf_q[ctr_addr] <= ctr_wdata;
         end
         // snapshot taken at the run edge
         if (run_req) begin
            for (int i = 0; i < `N_CONF; i++) begin
               shadow_q[i] <= conf_q[i];
            end
         end
         run_pulse <= run_req;
         // ports still show the previous run while run_pulse is high
         if (run_req) begin
            busy_q <= 1'b1;
         end else if (busy_q && !run_pulse && (&port_done)) begin
            busy_q <= 1'b0;
         end
         if (ctr_valid && !ctr_we) begin
            if (ctr_addr < `N_CONF) begin
               ctr_rdata <= conf_q[ctr_addr];
            end else if (ctr_addr == `RUN_ADDR) begin
               ctr_rdata <= data_t'(busy_q);
            end else begin
               ctr_rdata <= '0;
            end
         end
      end
   end

   for (genvar j = 0; j < 4*`N_MEM; j++) begin : g_mem_conf
      assign mem_conf[j] = shadow_q[`CONF_MEM0 + j];
   end

   for (genvar j = 0; j < `N_ALU; j++) begin : g_alu_conf
      assign alu_conf[j] = shadow_q[`CONF_ALU0 + j];
   end

   assign mul_conf = shadow_q[`CONF_MUL0];

endmodule

//--- hw/data_engine.sv
// ----------------------------------------------------------
// data engine top: shared data bus, host decode and units
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_params.svh"

module data_engine (
   input  logic                      rst,
   input  logic                      clk,
   // control interface
   input  logic                      ctr_valid,
   input  logic                      ctr_we,
   input  dataeng_pkg::ctr_addr_t    ctr_addr,
   input  dataeng_pkg::data_t        ctr_wdata,
   output dataeng_pkg::data_t        ctr_rdata,
   // data interface
   input  logic                      data_valid,
   input  logic                      data_we,
   input  logic [`DADDR_W-1:0]       data_addr,
   input  dataeng_pkg::data_t        data_wdata,
   output dataeng_pkg::data_t        data_rdata
);
   import dataeng_pkg::*;

   bus_t                      data_bus;
   data_t [4*`N_MEM-1:0]      mem_conf;
   data_t [`N_ALU-1:0]        alu_conf;
   data_t                     mul_conf;
   logic                      run_pulse;
   logic  [2*`N_MEM-1:0]      port_done;
   data_t [`N_MEM-1:0]        mem_rdata;
   logic                      rd_sel_q;

   // constant entries
   assign data_bus[`BUS_ZERO*`DATA_W +: `DATA_W] = '0;
   assign data_bus[`BUS_ONE*`DATA_W +: `DATA_W]  = data_t'(1);

   conf_regs u_conf (
      .rst       (rst),
      .clk       (clk),
      .ctr_valid (ctr_valid),
      .ctr_we    (ctr_we),
      .ctr_addr  (ctr_addr),
      .ctr_wdata (ctr_wdata),
      .ctr_rdata (ctr_rdata),
      .port_done (port_done),
      .mem_conf  (mem_conf),
      .alu_conf  (alu_conf),
      .mul_conf  (mul_conf),
      .run_pulse (run_pulse)
   );

   for (genvar i = 0; i < `N_MEM; i++) begin : g_mem
      mem_host_if u_hif ();

      // top address bit picks the memory
      assign u_hif.valid = data_valid && (int'(data_addr[`DADDR_W-1]) == i);
      assign u_hif.we    = data_we;
      assign u_hif.addr  = data_addr[`MEM_ADDR_W-1:0];
      assign u_hif.wdata = data_wdata;
      assign mem_rdata[i] = u_hif.rdata;

      data_mem u_mem (
         .rst       (rst),
         .clk       (clk),
         .run_pulse (run_pulse),
         .data_bus  (data_bus),
         .conf_a    (mem_conf[4*i +: 2]),
         .conf_b    (mem_conf[4*i+2 +: 2]),
         .out_a     (data_bus[(`BUS_MEM0A+2*i)*`DATA_W +: `DATA_W]),
         .out_b     (data_bus[(`BUS_MEM0A+2*i+1)*`DATA_W +: `DATA_W]),
         .done_a    (port_done[2*i]),
         .done_b    (port_done[2*i+1]),
         .host      (u_hif.mem)
      );
   end

   for (genvar i = 0; i < `N_ALU; i++) begin : g_alu
      alu_unit u_alu (
         .rst      (rst),
         .clk      (clk),
         .data_bus (data_bus),
         .conf     (alu_conf[i]),
         .result   (data_bus[(`BUS_ALU0+i)*`DATA_W +: `DATA_W])
      );
   end

   mul_unit u_mul (
      .rst      (rst),
      .clk      (clk),
      .data_bus (data_bus),
      .conf     (mul_conf),
      .result   (data_bus[`BUS_MUL0*`DATA_W +: `DATA_W])
   );

   // remember which memory was accessed for the read return
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rd_sel_q <= 1'b0;
      end else if (data_valid) begin
         rd_sel_q <= data_addr[`DADDR_W-1];
      end
   end

   assign data_rdata = mem_rdata[rd_sel_q];

endmodule

//--- hw/data_mem.sv
// ----------------------------------------------------------
// dual-port engine memory with two address generators
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_params.svh"

module data_mem (
   input  logic                          rst,
   input  logic                          clk,
   input  logic                          run_pulse,
   input  dataeng_pkg::bus_t             data_bus,
   input  dataeng_pkg::data_t [1:0]      conf_a,
   input  dataeng_pkg::data_t [1:0]      conf_b,
   output dataeng_pkg::data_t            out_a,
   output dataeng_pkg::data_t            out_b,
   output logic                          done_a,
   output logic                          done_b,
   mem_host_if.mem                       host
);
   import dataeng_pkg::*;

   data_t mem [2**`MEM_ADDR_W];

   // per port: index 0 is port A, index 1 is port B
   data_t [1:0]     port_w0;
   data_t [1:0]     port_w1;
   logic  [1:0]     issue;
   logic  [1:0]     port_we;
   logic  [1:0]     port_done;
   mem_addr_t [1:0] gen_addr;
   data_t [1:0]     port_wdata;
   data_t [1:0]     out_q;

   // port A muxed between engine and host
   mem_addr_t addr_a;
   data_t     wdata_a;
   logic      wr_a;
   logic      rd_a;
   logic      wr_b;
   logic      rd_b;
   logic      host_rd;
   data_t     host_q;

   assign port_w0 = {conf_b[0], conf_a[0]};
   assign port_w1 = {conf_b[1], conf_a[1]};

   for (genvar p = 0; p < 2; p++) begin : g_port
      port_state_e state_q;
      mem_addr_t   addr_q;
      logic [7:0]  left_q;
      logic [3:0]  dly_q;
      mem_addr_t   start;
      logic [7:0]  incr;
      logic [7:0]  count;
      logic        enable;
      logic [3:0]  delay;

      // word 0: start, increment, count. word 1: enable, write, source, delay
      assign start  = port_w0[p][7:0];
      assign incr   = port_w0[p][15:8];
      assign count  = port_w0[p][23:16];
      assign enable = port_w1[p][0];
      assign delay  = port_w1[p][11:8];

      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            state_q <= st_idle;
            addr_q  <= '0;
            left_q  <= '0;
            dly_q   <= '0;
         end else if (run_pulse) begin
            addr_q <= start;
            left_q <= count;
            dly_q  <= delay;
            if (!enable || count == 8'd0) begin
               state_q <= st_idle;
            end else if (delay != 4'd0) begin
               state_q <= st_wait;
            end else begin
               state_q <= st_run;
            end
         end else begin
            case (state_q)
               st_wait: begin
                  dly_q <= dly_q - 4'd1;
                  if (dly_q == 4'd1) begin
                     state_q <= st_run;
                  end
               end
               st_run: begin
                  // address wraps modulo the memory size
                  addr_q <= addr_q + incr;
                  left_q <= left_q - 8'd1;
                  if (left_q == 8'd1) begin
                     state_q <= st_idle;
                  end
               end
               default: begin
               end
            endcase
         end
      end

      assign issue[p]      = (state_q == st_run);
      assign port_done[p]  = (state_q == st_idle);
      assign gen_addr[p]   = addr_q;
      assign port_we[p]    = port_w1[p][1];
      assign port_wdata[p] = bus_pick(data_bus, bus_sel_t'(port_w1[p][7:4]));
   end

   assign addr_a  = issue[0] ? gen_addr[0] : host.addr;
   assign wdata_a = issue[0] ? port_wdata[0] : host.wdata;
   assign wr_a    = issue[0] ? port_we[0] : (host.valid && host.we);
   assign rd_a    = issue[0] && !port_we[0];
   assign host_rd = !issue[0] && host.valid && !host.we;
   assign wr_b    = issue[1] && port_we[1];
   assign rd_b    = issue[1] && !port_we[1];

   // port A written last so it wins an address clash
   always_ff @(posedge rst) begin
      if (wr_b) begin
         mem[gen_addr[1]] <= port_wdata[1];
      end
      if (wr_a) begin
         mem[addr_a] <= wdata_a;
      end
      if (host_rd) begin
         host_q <= mem[addr_a];
      end
   end

   // bus entries hold the last value read
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out_q <= '0;
      end else begin
         if (rd_a) begin
            out_q[0] <= mem[addr_a];
         end
         if (rd_b) begin
            out_q[1] <= mem[gen_addr[1]];
         end
      end
   end

   assign host.rdata = host_q;
   assign out_a      = out_q[0];
   assign out_b      = out_q[1];
   assign done_a     = port_done[0];
   assign done_b     = port_done[1];

endmodule

//--- hw/dataeng_params.svh
// ----------------------------------------------------------
// data engine parameters: widths, bus indices, config map
// ----------------------------------------------------------
`ifndef DATAENG_PARAMS_SVH
`define DATAENG_PARAMS_SVH

// word and address widths
`define DATA_W      32
`define MEM_ADDR_W  8
`define DADDR_W     9
`define CTR_ADDR_W  4
`define SEL_W       4

// unit counts
`define N_MEM       2
`define N_ALU       2
`define N_BUS       9

// data bus entry indices
`define BUS_ZERO    0
`define BUS_ONE     1
`define BUS_MEM0A   2
`define BUS_ALU0    6
`define BUS_MUL0    8

// configuration word addresses
`define N_CONF      11
`define CONF_MEM0   0
`define CONF_ALU0   8
`define CONF_MUL0   10
`define RUN_ADDR    15

`endif

//--- hw/dataeng_pkg.sv
// ----------------------------------------------------------
// data engine types, enums and bus entry selection
// ----------------------------------------------------------
`include "dataeng_params.svh"

package dataeng_pkg;

   typedef logic [`DATA_W-1:0]         data_t;
   typedef logic [`MEM_ADDR_W-1:0]     mem_addr_t;
   typedef logic [`SEL_W-1:0]          bus_sel_t;
   typedef logic [`N_BUS*`DATA_W-1:0]  bus_t;
   typedef logic [`CTR_ADDR_W-1:0]     ctr_addr_t;

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_and, alu_or,
      alu_xor, alu_max, alu_min, alu_pass_a
   } alu_op_e;

   typedef enum logic [1:0] {
      st_idle, st_wait, st_run
   } port_state_e;

   // entries past the end of the bus read as zero
   function automatic data_t bus_pick(bus_t bus, bus_sel_t sel);
      data_t word;
      word = '0;
      if (sel < `N_BUS) begin
         word = bus[sel*`DATA_W +: `DATA_W];
      end
      return word;
   endfunction

endpackage

//--- hw/mem_host_if.sv
// ----------------------------------------------------------
// host data-port access to one engine memory
// ----------------------------------------------------------
`timescale 1ns/1ps

interface mem_host_if;
   import dataeng_pkg::*;

   logic      valid;
   logic      we;
   mem_addr_t addr;
   data_t     wdata;
   // returned one cycle after a read access
   data_t     rdata;

   modport host (output valid, we, addr, wdata, input rdata);
   modport mem  (input valid, we, addr, wdata, output rdata);

endinterface

//--- hw/mul_unit.sv
// ----------------------------------------------------------
// two-stage pipelined multiplier fed from the data bus
// ----------------------------------------------------------
`timescale 1ns/1ps

module mul_unit (
   input  logic                rst,
   input  logic                clk,
   input  dataeng_pkg::bus_t   data_bus,
   input  dataeng_pkg::data_t  conf,
   output dataeng_pkg::data_t  result
);
   import dataeng_pkg::*;

   data_t op_a;
   data_t op_b;
   data_t a_q;
   data_t b_q;

   // operand selects in 3:0 and 7:4
   assign op_a = bus_pick(data_bus, bus_sel_t'(conf[3:0]));
   assign op_b = bus_pick(data_bus, bus_sel_t'(conf[7:4]));

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         a_q    <= '0;
         b_q    <= '0;
         result <= '0;
      end else begin
         // stage 1 captures operands
         a_q <= op_a;
         b_q <= op_b;
         // stage 2 keeps the low word of the product
         result <= a_q * b_q;
      end
   end

endmodule
